/* hw/cpuPkg.sv */
// Shared widths, opcodes and instruction formats for the pipelined core, imported by every stage
package cpuPkg;

  ////////////////////////////////////////////////////////////
  // Datapath and memory sizes
  ////////////////////////////////////////////////////////////
  localparam int dataWidth     = 16;                  // Data word and pc width
  localparam int regAddrWidth  = 4;                   // 16 registers, r0 reads zero
  localparam int imemDepth     = 256;                 // Instruction ROM words
  localparam int dmemDepth     = 256;                 // Data RAM words
  localparam int imemAddrWidth = $clog2(imemDepth);
  localparam int dmemAddrWidth = $clog2(dmemDepth);
  localparam     programFile   = "program.hex";       // ROM image, hex words

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////
  localparam logic [3:0] opAdd  = 4'h0;  // rd = rs + rt, all zero word doubles as nop
  localparam logic [3:0] opSub  = 4'h1;  // rd = rs - rt
  localparam logic [3:0] opAnd  = 4'h2;  // rd = rs & rt
  localparam logic [3:0] opXor  = 4'h3;  // rd = rs ^ rt
  localparam logic [3:0] opLdi  = 4'h4;  // rd = sext(imm8)
  localparam logic [3:0] opLw   = 4'h5;  // rd = mem[rs + rt field]
  localparam logic [3:0] opSw   = 4'h6;  // mem[rs + rt field] = rd
  localparam logic [3:0] opBeqz = 4'h7;  // if rd == 0, pc = pc + 1 + sext(imm8)
  localparam logic [3:0] opHlt  = 4'hF;  // Stop fetching, raise hlt at write-back

  ////////////////////////////////////////////////////////////
  // Instruction word, two views of the same 16 bits
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [3:0]              opcode;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;     // Register, or unsigned offset for lw and sw
  } rTypeFields;

  typedef struct packed {
    logic [3:0]              opcode;
    logic [regAddrWidth-1:0] rd;
    logic [7:0]              imm8;   // Two's complement immediate
  } iTypeFields;

  typedef union packed {
    rTypeFields rType;  // ALU ops, loads, stores
    iTypeFields iType;  // ldi and beqz
  } instrWord;

endpackage

/* hw/fetchUnit.sv */
// Fetch stage holding the pc, the program ROM and the IF/ID register, steered by decode
`timescale 1ns/1ps
module fetchUnit import cpuPkg::*; (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 stall,         // Hazard in decode, hold everything
  input  logic                 flush,         // Taken branch, squash the fetched word
  input  logic                 halted,        // HLT decoded, stop fetching
  input  logic [dataWidth-1:0] branchTarget,  // Redirect address on flush
  output logic [dataWidth-1:0] pc,
  output instrWord             ifIdInstr,
  output logic [dataWidth-1:0] ifIdPc         // Address of ifIdInstr
);

  logic [dataWidth-1:0] imem [imemDepth];  // Program ROM, word addressed
  instrWord             fetchWord;

  initial begin
    $readmemh(programFile, imem);
  end

  assign fetchWord = imem[pc[imemAddrWidth-1:0]];  // Asynchronous ROM read

  ////////////////////////////////////////////////////////////
  // PC and IF/ID register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc        <= '0;
      ifIdInstr <= '0;  // Bubble
      ifIdPc    <= '0;
    end else if (!stall) begin
      if (flush) begin
        pc        <= branchTarget;
        ifIdInstr <= '0;  // Drop the wrong-path word
      end else if (halted) begin
        ifIdInstr <= '0;  // pc frozen, later words discarded
      end else begin
        pc        <= pc + 1'b1;
        ifIdInstr <= fetchWord;
        ifIdPc    <= pc;
      end
    end
  end

  // A stalled cycle must leave fetch exactly where it was
  assert property (@(posedge clk) disable iff (!arstN)
    stall |=> $stable(pc) && $stable(ifIdInstr) && $stable(ifIdPc))
    else $error("fetch state changed across a stall");

endmodule

/* hw/decodeUnit.sv */
// Decode stage with register file, hazard detection, beqz resolution and the ID/EX register
`timescale 1ns/1ps
module decodeUnit import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  instrWord                ifIdInstr,
  input  logic [dataWidth-1:0]    ifIdPc,
  input  logic [regAddrWidth-1:0] exMemRd,        // Instruction in MEM, for branch hazards
  input  logic                    exMemRegWrite,
  input  logic                    regWriteEn,     // Retiring write from MEM/WB
  input  logic [regAddrWidth-1:0] regWriteAddr,
  input  logic [dataWidth-1:0]    regWriteData,
  output logic                    stall,
  output logic                    flush,
  output logic                    halted,
  output logic [dataWidth-1:0]    branchTarget,
  output logic [3:0]              idExOp,
  output logic [regAddrWidth-1:0] idExRd,
  output logic [regAddrWidth-1:0] idExRs,         // Source of operand A
  output logic [regAddrWidth-1:0] idExRt,         // Source of operand B, rd for stores
  output logic [dataWidth-1:0]    idExOpA,
  output logic [dataWidth-1:0]    idExOpB,
  output logic [dataWidth-1:0]    idExImm,
  output logic                    idExRegWrite,
  output logic                    idExMemRead,
  output logic                    idExMemWrite,
  output logic                    idExIsHalt
);

  logic [dataWidth-1:0]    regFile [1 << regAddrWidth];
  logic [3:0]              op;
  logic [regAddrWidth-1:0] rd, rs, srcB;
  logic [dataWidth-1:0]    immExt, imm, opA, opB, brVal;
  logic                    usesRs, usesB, wrReg, memRd, memWr, isBranch, isHalt;
  logic                    loadUse, branchHazard, haltSeen;

  // Register read with write-through of the retiring value
  function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
    if (addr == '0) return '0;
    if (regWriteEn && regWriteAddr == addr) return regWriteData;
    return regFile[addr];
  endfunction

  assign op     = ifIdInstr.rType.opcode;
  assign rd     = ifIdInstr.rType.rd;
  assign rs     = ifIdInstr.rType.rs;
  assign immExt = {{(dataWidth-8){ifIdInstr.iType.imm8[7]}}, ifIdInstr.iType.imm8};

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    usesRs   = 1'b0;
    usesB    = 1'b0;
    srcB     = ifIdInstr.rType.rt;
    wrReg    = 1'b0;
    memRd    = 1'b0;
    memWr    = 1'b0;
    isBranch = 1'b0;
    isHalt   = 1'b0;
    imm      = {{(dataWidth-regAddrWidth){1'b0}}, ifIdInstr.rType.rt};  // Word offset
    case (op)
      opAdd, opSub, opAnd, opXor: begin
        usesRs = 1'b1;
        usesB  = 1'b1;
        wrReg  = 1'b1;
      end
      opLdi: begin
        wrReg = 1'b1;
        imm   = immExt;
      end
      opLw: begin
        usesRs = 1'b1;
        wrReg  = 1'b1;
        memRd  = 1'b1;
      end
      opSw: begin
        usesRs = 1'b1;
        usesB  = 1'b1;
        srcB   = rd;  // Store data comes from rd
        memWr  = 1'b1;
      end
      opBeqz:  isBranch = 1'b1;
      opHlt:   isHalt   = 1'b1;
      default: ;  // nop
    endcase
    opA   = readReg(rs);
    opB   = readReg(srcB);
    brVal = readReg(rd);  // beqz tests rd
  end

  // Load in EX feeding this instruction costs one bubble
  assign loadUse = idExMemRead && idExRegWrite &&
                   ((usesRs && rs == idExRd) || (usesB && srcB == idExRd));
  // beqz waits until its register is in WB or the file
  assign branchHazard = isBranch && ((idExRegWrite && idExRd == rd) ||
                                     (exMemRegWrite && exMemRd == rd));
  assign stall        = loadUse || branchHazard;
  assign flush        = isBranch && !stall && brVal == '0;  // Predict not-taken
  assign branchTarget = ifIdPc + 1'b1 + immExt;
  assign halted       = haltSeen || isHalt;

  always_ff @(posedge clk) begin
    if (regWriteEn) begin
      regFile[regWriteAddr] <= regWriteData;
    end
  end

  ////////////////////////////////////////////////////////////
  // ID/EX register, bubble on stall
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idExRegWrite <= 1'b0;
      idExMemRead  <= 1'b0;
      idExMemWrite <= 1'b0;
      idExIsHalt   <= 1'b0;
      haltSeen     <= 1'b0;
    end else begin
      idExRegWrite <= !stall && wrReg && rd != '0;  // r0 writes are dropped here
      idExMemRead  <= !stall && memRd;
      idExMemWrite <= !stall && memWr;
      idExIsHalt   <= !stall && isHalt;
      haltSeen     <= haltSeen || isHalt;  // Sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    idExOp  <= op;
    idExRd  <= rd;
    idExRs  <= rs;
    idExRt  <= srcB;
    idExOpA <= opA;
    idExOpB <= opB;
    idExImm <= imm;
  end

  assert property (@(posedge clk) disable iff (!arstN) regWriteEn |-> regWriteAddr != '0)
    else $error("live register write to r0");
  assert property (@(posedge clk) disable iff (!arstN) !(flush && stall))
    else $error("branch flush raised during a stall");

endmodule

/* hw/executeUnit.sv */
// Execute stage with operand forwarding, the ALU and the EX/MEM register
`timescale 1ns/1ps
module executeUnit import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic [3:0]              idExOp,
  input  logic [regAddrWidth-1:0] idExRd,
  input  logic [regAddrWidth-1:0] idExRs,
  input  logic [regAddrWidth-1:0] idExRt,
  input  logic [dataWidth-1:0]    idExOpA,        // Register value read in decode
  input  logic [dataWidth-1:0]    idExOpB,
  input  logic [dataWidth-1:0]    idExImm,
  input  logic                    idExRegWrite,
  input  logic                    idExMemRead,
  input  logic                    idExMemWrite,
  input  logic                    idExIsHalt,
  input  logic                    regWriteEn,     // MEM/WB forwarding source
  input  logic [regAddrWidth-1:0] regWriteAddr,
  input  logic [dataWidth-1:0]    regWriteData,
  output logic [dataWidth-1:0]    exMemResult,    // ALU value or memory address
  output logic [dataWidth-1:0]    exMemStoreData,
  output logic [regAddrWidth-1:0] exMemRd,
  output logic                    exMemRegWrite,
  output logic                    exMemMemRead,
  output logic                    exMemMemWrite,
  output logic                    exMemIsHalt
);

  logic [dataWidth-1:0] srcA, srcB, aluOut;

  // Youngest producer wins, then MEM/WB, then the decode read
  function automatic logic [dataWidth-1:0] forward(input logic [regAddrWidth-1:0] src,
                                                   input logic [dataWidth-1:0]    regVal);
    if (exMemRegWrite && exMemRd == src) return exMemResult;
    if (regWriteEn && regWriteAddr == src) return regWriteData;
    return regVal;
  endfunction

  ////////////////////////////////////////////////////////////
  // Forwarding and ALU
  ////////////////////////////////////////////////////////////
  always_comb begin
    srcA = forward(idExRs, idExOpA);
    srcB = forward(idExRt, idExOpB);  // Store data on sw
    case (idExOp)
      opAdd:      aluOut = srcA + srcB;
      opSub:      aluOut = srcA - srcB;
      opAnd:      aluOut = srcA & srcB;
      opXor:      aluOut = srcA ^ srcB;
      opLdi:      aluOut = idExImm;          // Pass-through
      opLw, opSw: aluOut = srcA + idExImm;   // Base plus word offset
      default:    aluOut = '0;
    endcase
  end

  // EX/MEM control
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMemRegWrite <= 1'b0;
      exMemMemRead  <= 1'b0;
      exMemMemWrite <= 1'b0;
      exMemIsHalt   <= 1'b0;
    end else begin
      exMemRegWrite <= idExRegWrite;
      exMemMemRead  <= idExMemRead;
      exMemMemWrite <= idExMemWrite;
      exMemIsHalt   <= idExIsHalt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    exMemResult    <= aluOut;
    exMemStoreData <= srcB;
    exMemRd        <= idExRd;
  end

  // Decode never marks one instruction as both load and store
  assert property (@(posedge clk) disable iff (!arstN) !(exMemMemRead && exMemMemWrite))
    else $error("load and store flagged together in MEM");

endmodule

/* hw/memWriteback.sv */
// Memory and write-back stages with data RAM, MEM/WB register and the sticky halt flag
`timescale 1ns/1ps
module memWriteback import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic [dataWidth-1:0]    exMemResult,
  input  logic [dataWidth-1:0]    exMemStoreData,
  input  logic [regAddrWidth-1:0] exMemRd,
  input  logic                    exMemRegWrite,
  input  logic                    exMemMemRead,
  input  logic                    exMemMemWrite,
  input  logic                    exMemIsHalt,
  output logic                    regWriteEn,
  output logic [regAddrWidth-1:0] regWriteAddr,
  output logic [dataWidth-1:0]    regWriteData,
  output logic                    hlt             // High once HLT reaches MEM/WB
);

  logic [dataWidth-1:0]     dmem [dmemDepth];
  logic [dmemAddrWidth-1:0] memAddr;
  logic [dataWidth-1:0]     loadData;

  assign memAddr  = exMemResult[dmemAddrWidth-1:0];  // Word address, upper bits ignored
  assign loadData = dmem[memAddr];                   // Combinational read

  always_ff @(posedge clk) begin
    if (exMemMemWrite) begin
      dmem[memAddr] <= exMemStoreData;
    end
  end

  ////////////////////////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteEn <= 1'b0;
      hlt        <= 1'b0;
    end else begin
      regWriteEn <= exMemRegWrite;
      hlt        <= hlt || exMemIsHalt;  // Sticky
    end
  end

  always_ff @(posedge clk) begin
    regWriteAddr <= exMemRd;
    regWriteData <= exMemMemRead ? loadData : exMemResult;  // Load data or ALU value
  end

  // Halt holds until reset
  assert property (@(posedge clk) disable iff (!arstN) hlt |=> hlt)
    else $error("hlt dropped without reset");

endmodule

/* hw/cpuModel.sv */
// Top of the five-stage core, wiring fetch, decode, execute and memory/write-back together
`timescale 1ns/1ps
module cpuModel import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  output logic                    hlt,
  output logic [dataWidth-1:0]    pc,
  output logic                    regWriteEn,     // Retiring register write
  output logic [regAddrWidth-1:0] regWriteAddr,
  output logic [dataWidth-1:0]    regWriteData
);

  // Fetch to decode, and decode steering back to fetch
  logic                    stall, flush, halted;
  logic [dataWidth-1:0]    branchTarget, ifIdPc;
  instrWord                ifIdInstr;

  // ID/EX fields
  logic [3:0]              idExOp;
  logic [regAddrWidth-1:0] idExRd, idExRs, idExRt;
  logic [dataWidth-1:0]    idExOpA, idExOpB, idExImm;
  logic                    idExRegWrite, idExMemRead, idExMemWrite, idExIsHalt;

  // EX/MEM fields
  logic [dataWidth-1:0]    exMemResult, exMemStoreData;
  logic [regAddrWidth-1:0] exMemRd;
  logic                    exMemRegWrite, exMemMemRead, exMemMemWrite, exMemIsHalt;

  ////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////
  fetchUnit iFetch (
    .clk(clk), .arstN(arstN), .stall(stall), .flush(flush), .halted(halted),
    .branchTarget(branchTarget), .pc(pc), .ifIdInstr(ifIdInstr), .ifIdPc(ifIdPc)
  );

  decodeUnit iDecode (
    .clk(clk), .arstN(arstN), .ifIdInstr(ifIdInstr), .ifIdPc(ifIdPc),
    .exMemRd(exMemRd), .exMemRegWrite(exMemRegWrite),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
    .stall(stall), .flush(flush), .halted(halted), .branchTarget(branchTarget),
    .idExOp(idExOp), .idExRd(idExRd), .idExRs(idExRs), .idExRt(idExRt),
    .idExOpA(idExOpA), .idExOpB(idExOpB), .idExImm(idExImm),
    .idExRegWrite(idExRegWrite), .idExMemRead(idExMemRead),
    .idExMemWrite(idExMemWrite), .idExIsHalt(idExIsHalt)
  );

  executeUnit iExecute (
    .clk(clk), .arstN(arstN),
    .idExOp(idExOp), .idExRd(idExRd), .idExRs(idExRs), .idExRt(idExRt),
    .idExOpA(idExOpA), .idExOpB(idExOpB), .idExImm(idExImm),
    .idExRegWrite(idExRegWrite), .idExMemRead(idExMemRead),
    .idExMemWrite(idExMemWrite), .idExIsHalt(idExIsHalt),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
    .exMemResult(exMemResult), .exMemStoreData(exMemStoreData), .exMemRd(exMemRd),
    .exMemRegWrite(exMemRegWrite), .exMemMemRead(exMemMemRead),
    .exMemMemWrite(exMemMemWrite), .exMemIsHalt(exMemIsHalt)
  );

  memWriteback iMemWb (
    .clk(clk), .arstN(arstN),
    .exMemResult(exMemResult), .exMemStoreData(exMemStoreData), .exMemRd(exMemRd),
    .exMemRegWrite(exMemRegWrite), .exMemMemRead(exMemMemRead),
    .exMemMemWrite(exMemMemWrite), .exMemIsHalt(exMemIsHalt),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
    .hlt(hlt)
  );

endmodule

/* tb/clockGen.sv */
// Testbench clock and reset source for the core, 20 ns period with reset held for two cycles
`timescale 1ns/1ps
module clockGen (
  output logic clk,
  output logic arstN
);

  localparam int halfPeriodNs = 10;  // 20 ns period
  localparam int resetCycles  = 2;

  initial begin
    clk   = 1'b0;
    arstN = 1'b0;                    // Reset from time zero
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;                    // Release on a falling edge
  end

  always #halfPeriodNs clk = ~clk;

endmodule

/* tb/cpuModelTb.sv */
// Testbench for cpuModel where an instruction-set model of program.hex predicts the retiring writes
`timescale 1ns/1ps
module cpuModelTb import cpuPkg::*; ();

  localparam int clkPeriodNs    = 20;
  localparam int programLength  = 24;                     // Instructions budgeted per run
  localparam int watchdogCycles = programLength * 3 + 40;
  localparam int settleCycles   = 10;                     // Observed after hlt rises
  localparam int maxModelSteps  = 1000;

  logic                    clk, arstN, hlt, regWriteEn;
  logic [dataWidth-1:0]    pc, regWriteData;
  logic [regAddrWidth-1:0] regWriteAddr;

  logic [dataWidth-1:0]    romImage [imemDepth];          // Model copy of the program
  logic [regAddrWidth-1:0] expAddr [$];                   // Expected writes in program order
  logic [dataWidth-1:0]    expData [$];
  string                   expName [$];
  logic [regAddrWidth-1:0] headAddr;
  logic [dataWidth-1:0]    headData, finalPc;
  string                   headName;
  int                      pending, retireCount, valueErrors, otherErrors;
  logic                    resetWindow = 1'b1;            // Until the first active edge

  clockGen iClock (.clk(clk), .arstN(arstN));

  cpuModel DUT (
    .clk(clk), .arstN(arstN), .hlt(hlt), .pc(pc),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
  );

  function automatic string mnemonic(input logic [3:0] op);
    case (op)
      opAdd:   return "add";
      opSub:   return "sub";
      opAnd:   return "and";
      opXor:   return "xor";
      opLdi:   return "ldi";
      opLw:    return "lw";
      default: return "other";
    endcase
  endfunction

  // Front of the expected queue for the checks
  task automatic loadHead();
    pending = expAddr.size();
    if (pending > 0) begin
      headAddr = expAddr[0];
      headData = expData[0];
      headName = $sformatf("retire %0d (%s)", retireCount, expName[0]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Instruction-set model stepping one instruction at a time
  ////////////////////////////////////////////////////////////
  task automatic buildModel();
    instrWord             iw;
    logic [dataWidth-1:0] regs [1 << regAddrWidth];
    logic [dataWidth-1:0] mem [dmemDepth];
    logic [dataWidth-1:0] mpc, nextPc, sext, result, addr, offset;
    logic                 writes;
    int                   step, i;
    bit                   done;
    $readmemh(programFile, romImage);
    for (i = 0; i < (1 << regAddrWidth); i++) begin
      regs[i] = '0;
    end
    mpc  = '0;
    done = 1'b0;
    step = 0;
    while (!done) begin
      iw     = romImage[mpc[imemAddrWidth-1:0]];
      sext   = {{(dataWidth-8){iw.iType.imm8[7]}}, iw.iType.imm8};
      offset = {{(dataWidth-regAddrWidth){1'b0}}, iw.rType.rt};  // Unsigned word offset
      addr   = regs[iw.rType.rs] + offset;
      nextPc = mpc + 1'b1;
      writes = 1'b1;
      result = '0;
      case (iw.rType.opcode)
        opAdd: result = regs[iw.rType.rs] + regs[iw.rType.rt];
        opSub: result = regs[iw.rType.rs] - regs[iw.rType.rt];
        opAnd: result = regs[iw.rType.rs] & regs[iw.rType.rt];
        opXor: result = regs[iw.rType.rs] ^ regs[iw.rType.rt];
        opLdi: result = sext;
        opLw:  result = mem[addr[dmemAddrWidth-1:0]];
        opSw: begin
          mem[addr[dmemAddrWidth-1:0]] = regs[iw.rType.rd];  // Data from rd
          writes = 1'b0;
        end
        opBeqz: begin
          writes = 1'b0;
          if (regs[iw.iType.rd] == '0) nextPc = mpc + 1'b1 + sext;
        end
        opHlt: begin
          writes  = 1'b0;
          done    = 1'b1;
          finalPc = nextPc;  // pc stops just past HLT
        end
        default: begin
          writes = 1'b0;
          done   = 1'b1;
          otherErrors++;
          $display("Model met an unknown opcode %h at pc %h", iw.rType.opcode, mpc);
        end
      endcase
      if (writes && iw.rType.rd != '0) begin  // r0 never changes
        regs[iw.rType.rd] = result;
        expAddr.push_back(iw.rType.rd);
        expData.push_back(result);
        expName.push_back(mnemonic(iw.rType.opcode));
      end
      mpc = nextPc;
      step++;
      if (!done && step >= maxModelSteps) begin
        otherErrors++;
        $display("Model found no HLT within %0d steps", maxModelSteps);
        done = 1'b1;
      end
    end
  endtask

  // Consume one expected write per retiring write
  always @(posedge clk) begin
    if (arstN) resetWindow <= 1'b0;
    if (arstN && regWriteEn && pending > 0) begin
      expAddr.delete(0);
      expData.delete(0);
      expName.delete(0);
      retireCount++;
      loadHead();
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks sampled mid-cycle where outputs are settled
  ////////////////////////////////////////////////////////////
  assert property (@(negedge clk) resetWindow |-> (!hlt && !regWriteEn && pc == '0))
    else begin
      valueErrors++;
      $display("FAILED reset state: expected hlt=0 regWriteEn=0 pc=0000, %s",
               $sformatf("actual hlt=%b regWriteEn=%b pc=%h", hlt, regWriteEn, pc));
    end
  assert property (@(negedge clk) disable iff (!arstN) regWriteEn |-> pending > 0)
    else begin
      otherErrors++;
      $display("Register write to r%0d retired with no write left in the model", regWriteAddr);
    end
  assert property (@(negedge clk) disable iff (!arstN)
    (regWriteEn && pending > 0) |-> (regWriteAddr == headAddr && regWriteData == headData))
    else begin
      valueErrors++;
      $display("FAILED %s: expected r%0d=%h, actual r%0d=%h",
               headName, headAddr, headData, regWriteAddr, regWriteData);
    end
  assert property (@(negedge clk) disable iff (!arstN) hlt |-> pending == 0)
    else begin
      otherErrors++;
      $display("hlt rose with %0d expected writes still missing", pending);
    end
  assert property (@(negedge clk) disable iff (!arstN) hlt |-> !regWriteEn)
    else begin
      otherErrors++;
      $display("A register write retired while hlt was high");
    end
  assert property (@(negedge clk) disable iff (!arstN) hlt |-> pc == finalPc)
    else begin
      valueErrors++;
      $display("FAILED halt pc: expected %h, actual %h", finalPc, pc);
    end
  assert property (@(negedge clk) disable iff (!arstN) hlt |=> (hlt && $stable(pc)))
    else begin
      otherErrors++;
      $display("hlt fell or pc moved after the core halted");
    end

  // Watchdog sized from the program budget
  initial begin
    #(watchdogCycles * clkPeriodNs);
    $display("Timeout: hlt did not rise within %0d cycles", watchdogCycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    buildModel();
    loadHead();
    wait (hlt === 1'b1);
    repeat (settleCycles) @(negedge clk);  // Let the halt checks run
    $display("Error counts: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* program.hex */
// One 16-bit instruction per line, nibbles are opcode, rd, then rs and rt or an imm8
// Word index is the pc, starting at zero
4105  // ldi  r1, 5
4203  // ldi  r2, 3
0312  // add  r3, r1, r2      forwarded from EX/MEM and MEM/WB
1432  // sub  r4, r3, r2      back-to-back dependency
2541  // and  r5, r4, r1
3653  // xor  r6, r5, r3
47FE  // ldi  r7, -2
6604  // sw   r6, [r0+4]
5804  // lw   r8, [r0+4]      store then load
0981  // add  r9, r8, r1      load-use bubble
6712  // sw   r7, [r1+2]
5A24  // lw   r10, [r2+4]     same word as the store above
7901  // beqz r9, +1          not taken
1B11  // sub  r11, r1, r1
7B01  // beqz r11, +1         taken, operand from the previous instruction
4C77  // ldi  r12, 0x77       wrong path
0CA2  // add  r12, r10, r2
7001  // beqz r0, +1          taken
4D11  // ldi  r13, 0x11       wrong path
4009  // ldi  r0, 9           write to r0 is dropped
F000  // hlt
4E33  // ldi  r14, 0x33       past the halt

/* sim.f */
hw/cpuPkg.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/executeUnit.sv
hw/memWriteback.sv
hw/cpuModel.sv
tb/clockGen.sv
tb/cpuModelTb.sv

/* run.sh */
#!/bin/sh
# Build the cpuModel testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module cpuModelTb -f sim.f

status=0
./obj_dir/VcpuModelTb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
exit 0
